/* hdl/disk_pkg.sv */
// Floppy geometry types; the 4-bit sector counter limits a track to 16 sectors
`default_nettype none

package disk_pkg;

    ////////////////////////////////////////
    // Disk and SD host types
    ////////////////////////////////////////

    // Head position, 35 tracks fit with room to spare
    typedef logic [5:0] track_t;

    // Sector counter within one track
    typedef logic [3:0] sector_t;

    // SD logical block address
    typedef logic [31:0] lba_t;

    // Size of the mounted image, zero when nothing is mounted
    typedef logic [63:0] img_size_t;

    ////////////////////////////////////////
    // Defaults for the top level
    ////////////////////////////////////////

    // 13 sectors of 512 bytes hold one nibble track
    localparam int SECTORS_PER_TRACK_DEF = 13;

    // Reset counter width, top bit marks end of hold
    localparam int RESET_HOLD_BITS_DEF = 23;

endpackage

`default_nettype wire

/* hdl/video_pkg.sv */
// Colour types and palette; 4-bit palette nibbles widen to 5-bit channels
`default_nettype none

package video_pkg;

    ////////////////////////////////////////
    // Video types
    ////////////////////////////////////////

    // Palette index from the video generator
    typedef logic [3:0] color_index_t;

    // One output colour channel
    typedef logic [4:0] channel_t;

    // Brightness of the odd scanlines
    typedef enum logic [1:0] {
        SCAN_OFF   = 2'd0,
        SCAN_DIM25 = 2'd1,
        SCAN_DIM50 = 2'd2,
        SCAN_DIM75 = 2'd3
    } scan_mode_t;

    // Packed as R, G, unused, B nibbles
    typedef logic [15:0] palette_entry_t;

    ////////////////////////////////////////
    // Apple-style colour table
    ////////////////////////////////////////

    localparam palette_entry_t PALETTE [0:15] = '{
        16'h0000,  // Black
        16'h9104,  // Red
        16'h420A,  // Dark blue
        16'hD405,  // Purple
        16'h0604,  // Dark green
        16'h8808,  // Gray 1
        16'h290E,  // Medium blue
        16'hBA0F,  // Light blue
        16'h4500,  // Brown
        16'hD601,  // Orange
        16'h8808,  // Gray 2
        16'hF90B,  // Pink
        16'h2B01,  // Light green
        16'hBD05,  // Yellow
        16'h6E0B,  // Aqua
        16'hFF0F   // White
    };

    // Overlay timer width, about 4M cycles of afterglow
    localparam int ACTIVITY_TIMER_BITS_DEF = 22;

endpackage

`default_nettype wire

/* hdl/reset_sequencer.sv */
// Core reset hold of 2^(HOLD_BITS-1)+1 cycles; every new request restarts the count
`default_nettype none
`timescale 1ns/1ps

module reset_sequencer #(
    parameter int HOLD_BITS = disk_pkg::RESET_HOLD_BITS_DEF
) (
    input  wire  clk_sys,
    input  wire  reset,
    input  logic reset_req_i,
    output logic core_reset_o
);

    // Increment step, sized to the counter
    localparam logic [HOLD_BITS-1:0] CNT_ONE = 1;

    // Free-running hold counter
    logic [HOLD_BITS-1:0] hold_cnt;

    ////////////////////////////////////////
    // Power-on style reset stretch
    ////////////////////////////////////////

    // Stands in for the 555 timer of the real machine
    always_ff @(posedge clk_sys) begin
        if (reset || reset_req_i) begin
            // Any request restarts the hold
            hold_cnt     <= '0;
            core_reset_o <= 1'b1;
        end else begin
            // Release one edge after the top bit shows up
            if (hold_cnt[HOLD_BITS-1]) begin
                core_reset_o <= 1'b0;
            end
            // Counter keeps running, wrap is harmless
            hold_cnt <= hold_cnt + CNT_ONE;
        end
    end

endmodule

`default_nettype wire

/* hdl/track_loader.sv */
// Loads one whole track per head move or mount; sd_rd_o/sd_ack_i are plain levels, no timeout
`default_nettype none
`timescale 1ns/1ps

module track_loader #(
    parameter int SECTORS_PER_TRACK = disk_pkg::SECTORS_PER_TRACK_DEF
) (
    input  wire                 clk_sys,
    input  wire                 reset,
    input  disk_pkg::track_t    track_i,
    input  logic                img_mounted_i,
    input  disk_pkg::img_size_t img_size_i,
    input  logic                sd_ack_i,
    output logic                sd_rd_o,
    output disk_pkg::lba_t      sd_lba_o,
    output logic                cpu_wait_o
);

    typedef enum logic {
        ST_IDLE,
        ST_LOADING
    } load_state_t;

    // Last sector index of a track
    localparam disk_pkg::sector_t LAST_SECTOR = disk_pkg::sector_t'(SECTORS_PER_TRACK - 1);

    load_state_t       state;
    disk_pkg::track_t  cur_track;
    disk_pkg::sector_t sector_cnt;
    logic              mount_pending;
    logic              ack_q;
    logic              ack_rise;
    logic              ack_fall;

    // Edges of the host acknowledge
    assign ack_rise = sd_ack_i & ~ack_q;
    assign ack_fall = ~sd_ack_i & ack_q;

    ////////////////////////////////////////
    // Load FSM
    ////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state         <= ST_IDLE;
            sd_rd_o       <= 1'b0;
            cpu_wait_o    <= 1'b0;
            cur_track     <= '0;
            mount_pending <= 1'b0;
            ack_q         <= 1'b0;
        end else begin
            ack_q <= sd_ack_i;
            // Remember a mount until idle can act on it
            if (img_mounted_i) begin
                mount_pending <= 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    // Head moved, or the mount pulse is over
                    if (cur_track != track_i || (mount_pending && !img_mounted_i)) begin
                        cur_track     <= track_i;
                        mount_pending <= 1'b0;
                        // No image, nothing to fetch
                        if (img_size_i != '0) begin
                            sector_cnt <= '0;
                            sd_lba_o   <= disk_pkg::lba_t'(SECTORS_PER_TRACK)
                                          * disk_pkg::lba_t'(track_i);
                            sd_rd_o    <= 1'b1;
                            cpu_wait_o <= 1'b1;
                            state      <= ST_LOADING;
                        end
                    end
                end
                ST_LOADING: begin
                    if (ack_rise) begin
                        // Host took this block, drop request on the last one
                        if (sector_cnt >= LAST_SECTOR) begin
                            sd_rd_o <= 1'b0;
                        end
                        sd_lba_o <= sd_lba_o + disk_pkg::lba_t'(1);
                    end else if (ack_fall) begin
                        sector_cnt <= sector_cnt + disk_pkg::sector_t'(1);
                        // CPU only waits for the first sector
                        cpu_wait_o <= 1'b0;
                        if (!sd_rd_o) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/activity_timer.sv */
// Overlay stays lit 2^TIMER_BITS cycles after the last drive access
`default_nettype none
`timescale 1ns/1ps

module activity_timer #(
    parameter int TIMER_BITS = video_pkg::ACTIVITY_TIMER_BITS_DEF
) (
    input  wire  clk_sys,
    input  wire  reset,
    input  logic drive_active_i,
    output logic overlay_o
);

    // Decrement step, sized to the timer
    localparam logic [TIMER_BITS-1:0] TIMER_ONE = 1;

    logic [TIMER_BITS-1:0] timer_q;

    // Reloadable down-counter
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            timer_q   <= '0;
            overlay_o <= 1'b0;
        end else if (drive_active_i) begin
            // Drive busy, restart afterglow
            timer_q   <= '1;
            overlay_o <= 1'b1;
        end else if (timer_q != '0) begin
            timer_q   <= timer_q - TIMER_ONE;
            overlay_o <= 1'b1;
        end else begin
            // Expired
            overlay_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/palette_shader.sv */
// One-cycle registered colour stage; overlay overrides green in every scanline mode
`default_nettype none
`timescale 1ns/1ps

module palette_shader (
    input  wire                       clk_sys,
    input  wire                       reset,
    input  video_pkg::color_index_t   color_index_i,
    input  logic                      odd_line_i,
    input  video_pkg::scan_mode_t     scanline_mode_i,
    input  logic                      overlay_i,
    output video_pkg::channel_t       vga_r_o,
    output video_pkg::channel_t       vga_g_o,
    output video_pkg::channel_t       vga_b_o
);

    // Widen one nibble, dimmed on odd lines
    function automatic video_pkg::channel_t shade(
        input logic [3:0]            nib,
        input logic                  odd,
        input video_pkg::scan_mode_t mode
    );
        video_pkg::channel_t res;
        if (!odd || mode == video_pkg::SCAN_OFF) begin
            // Full brightness, low bit repeated
            res = {nib, nib[0]};
        end else begin
            case (mode)
                // 1/2 + 1/4 of full scale
                video_pkg::SCAN_DIM25: res = {1'b0, nib} + {2'b00, nib[3:1]};
                video_pkg::SCAN_DIM50: res = {1'b0, nib};
                // Quarter scale
                default:               res = {2'b00, nib[3:1]};
            endcase
        end
        return res;
    endfunction

    video_pkg::palette_entry_t entry;
    video_pkg::channel_t       r_next;
    video_pkg::channel_t       g_next;
    video_pkg::channel_t       b_next;

    ////////////////////////////////////////
    // Lookup and dimming
    ////////////////////////////////////////

    always_comb begin
        entry  = video_pkg::PALETTE[color_index_i];
        r_next = shade(entry[15:12], odd_line_i, scanline_mode_i);
        // Disk indicator wins on green
        g_next = overlay_i ? '1 : shade(entry[11:8], odd_line_i, scanline_mode_i);
        b_next = shade(entry[3:0], odd_line_i, scanline_mode_i);
    end

    // Output register
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            vga_r_o <= '0;
            vga_g_o <= '0;
            vga_b_o <= '0;
        end else begin
            vga_r_o <= r_next;
            vga_g_o <= g_next;
            vga_b_o <= b_next;
        end
    end

endmodule

`default_nettype wire

/* hdl/tk2000_support.sv */
// TK2000 support logic on one clock; all inputs assumed synchronous to clk_sys
`default_nettype none
`timescale 1ns/1ps

module tk2000_support #(
    parameter int SECTORS_PER_TRACK   = disk_pkg::SECTORS_PER_TRACK_DEF,
    parameter int RESET_HOLD_BITS     = disk_pkg::RESET_HOLD_BITS_DEF,
    parameter int ACTIVITY_TIMER_BITS = video_pkg::ACTIVITY_TIMER_BITS_DEF
) (
    input  wire                     clk_sys,
    input  wire                     reset,
    // Reset request from menu or buttons
    input  logic                    reset_req_i,
    output logic                    core_reset_o,
    // Floppy track fetch
    input  disk_pkg::track_t        track_i,
    input  logic                    img_mounted_i,
    input  disk_pkg::img_size_t     img_size_i,
    input  logic                    sd_ack_i,
    output logic                    sd_rd_o,
    output disk_pkg::lba_t          sd_lba_o,
    output logic                    cpu_wait_o,
    // Video colour stage
    input  logic                    drive_active_i,
    input  video_pkg::color_index_t color_index_i,
    input  logic                    odd_line_i,
    input  video_pkg::scan_mode_t   scanline_mode_i,
    output video_pkg::channel_t     vga_r_o,
    output video_pkg::channel_t     vga_g_o,
    output video_pkg::channel_t     vga_b_o
);

    // Disk indicator into the shader
    logic overlay;

    reset_sequencer #(
        .HOLD_BITS(RESET_HOLD_BITS)
    ) u_reset_sequencer (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .reset_req_i (reset_req_i),
        .core_reset_o(core_reset_o)
    );

    track_loader #(
        .SECTORS_PER_TRACK(SECTORS_PER_TRACK)
    ) u_track_loader (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .track_i      (track_i),
        .img_mounted_i(img_mounted_i),
        .img_size_i   (img_size_i),
        .sd_ack_i     (sd_ack_i),
        .sd_rd_o      (sd_rd_o),
        .sd_lba_o     (sd_lba_o),
        .cpu_wait_o   (cpu_wait_o)
    );

    activity_timer #(
        .TIMER_BITS(ACTIVITY_TIMER_BITS)
    ) u_activity_timer (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .drive_active_i(drive_active_i),
        .overlay_o     (overlay)
    );

    palette_shader u_palette_shader (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .color_index_i  (color_index_i),
        .odd_line_i     (odd_line_i),
        .scanline_mode_i(scanline_mode_i),
        .overlay_i      (overlay),
        .vga_r_o        (vga_r_o),
        .vga_g_o        (vga_g_o),
        .vga_b_o        (vga_b_o)
    );

endmodule

`default_nettype wire

/* tests/tk2000_support_props.sv */
// Checks hold only for the clk_sys domain; bound into every tk2000_support instance
`default_nettype none
`timescale 1ns/1ps

module tk2000_support_props (
    input wire  clk_sys,
    input wire  reset,
    input logic reset_req_i,
    input logic core_reset_o,
    input logic sd_rd_o,
    input logic cpu_wait_o
);

    ////////////////////////////////////////
    // Reset and loader rules
    ////////////////////////////////////////

    // Loader idle right after reset
    assert property (@(posedge clk_sys) reset |=> !sd_rd_o)
        else $error("sd_rd_o high in the cycle after reset");

    // Request always reaches the core
    assert property (@(posedge clk_sys) reset_req_i |=> core_reset_o)
        else $error("core_reset_o low in the cycle after reset_req_i");

    // CPU stall only starts with a new load
    assert property (@(posedge clk_sys) disable iff (reset)
        $rose(cpu_wait_o) |-> $rose(sd_rd_o))
        else $error("cpu_wait_o rose without sd_rd_o");

endmodule

bind tk2000_support tk2000_support_props u_props (
    .clk_sys     (clk_sys),
    .reset       (reset),
    .reset_req_i (reset_req_i),
    .core_reset_o(core_reset_o),
    .sd_rd_o     (sd_rd_o),
    .cpu_wait_o  (cpu_wait_o)
);

`default_nettype wire

/* tests/tb_tk2000_support.sv */
// Small parameters (13 sectors, 4-bit reset hold, 3-bit overlay timer); SD host modelled inline
`default_nettype none
`timescale 1ns/1ps

module tb_tk2000_support;

    localparam int SECTORS_PER_TRACK   = 13;
    localparam int RESET_HOLD_BITS     = 4;
    localparam int ACTIVITY_TIMER_BITS = 3;
    // Edges from request to release, and from pulse to overlay off
    localparam int RESET_EDGES   = 2 ** (RESET_HOLD_BITS - 1) + 1;
    localparam int OVERLAY_EDGES = 2 ** ACTIVITY_TIMER_BITS;
    // Cycles allowed for the loader to raise its request
    localparam int REQ_TIMEOUT   = 20;
    // 35 tracks of 16 sectors of 256 bytes
    localparam disk_pkg::img_size_t IMG_BYTES = 64'd143360;

    logic                    clk_sys = 1'b0;
    logic                    reset;
    logic                    reset_req_i;
    logic                    core_reset_o;
    disk_pkg::track_t        track_i;
    logic                    img_mounted_i;
    disk_pkg::img_size_t     img_size_i;
    logic                    sd_ack_i;
    logic                    sd_rd_o;
    disk_pkg::lba_t          sd_lba_o;
    logic                    cpu_wait_o;
    logic                    drive_active_i;
    video_pkg::color_index_t color_index_i;
    logic                    odd_line_i;
    video_pkg::scan_mode_t   scanline_mode_i;
    video_pkg::channel_t     vga_r_o;
    video_pkg::channel_t     vga_g_o;
    video_pkg::channel_t     vga_b_o;

    int          seed = 74516;
    logic [14:0] exp_rgb;

    always #5 clk_sys = ~clk_sys;

    tk2000_support #(
        .SECTORS_PER_TRACK  (SECTORS_PER_TRACK),
        .RESET_HOLD_BITS    (RESET_HOLD_BITS),
        .ACTIVITY_TIMER_BITS(ACTIVITY_TIMER_BITS)
    ) UUT (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .reset_req_i    (reset_req_i),
        .core_reset_o   (core_reset_o),
        .track_i        (track_i),
        .img_mounted_i  (img_mounted_i),
        .img_size_i     (img_size_i),
        .sd_ack_i       (sd_ack_i),
        .sd_rd_o        (sd_rd_o),
        .sd_lba_o       (sd_lba_o),
        .cpu_wait_o     (cpu_wait_o),
        .drive_active_i (drive_active_i),
        .color_index_i  (color_index_i),
        .odd_line_i     (odd_line_i),
        .scanline_mode_i(scanline_mode_i),
        .vga_r_o        (vga_r_o),
        .vga_g_o        (vga_g_o),
        .vga_b_o        (vga_b_o)
    );

    ////////////////////////////////////////
    // Error exit and compare tasks
    ////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_channel(input string what, input video_pkg::channel_t got,
                                 input video_pkg::channel_t exp);
        if (got !== exp)
            fail_run($sformatf("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_lba(input string what, input disk_pkg::lba_t got,
                             input disk_pkg::lba_t exp);
        if (got !== exp)
            fail_run($sformatf("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("Fail %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // One channel, scaled as integers
    function automatic video_pkg::channel_t ref_level(input logic [3:0] nib, input logic odd,
                                                      input video_pkg::scan_mode_t mode);
        int n;
        int v;
        n = int'(nib);
        if (odd && mode == video_pkg::SCAN_DIM25)
            v = n + n / 2;
        else if (odd && mode == video_pkg::SCAN_DIM50)
            v = n;
        else if (odd && mode == video_pkg::SCAN_DIM75)
            v = n / 2;
        else
            v = n * 2 + n % 2;
        return video_pkg::channel_t'(v);
    endfunction

    // Packed as {r, g, b}
    function automatic logic [14:0] ref_rgb(input video_pkg::color_index_t idx, input logic odd,
                                            input video_pkg::scan_mode_t mode, input logic ovl);
        video_pkg::palette_entry_t e;
        video_pkg::channel_t       g;
        e = video_pkg::PALETTE[idx];
        g = ovl ? 5'd31 : ref_level(e[11:8], odd, mode);
        return {ref_level(e[15:12], odd, mode), g, ref_level(e[3:0], odd, mode)};
    endfunction

    function automatic disk_pkg::lba_t ref_first_lba(input disk_pkg::track_t trk);
        return disk_pkg::lba_t'(SECTORS_PER_TRACK * int'(trk));
    endfunction

    // Random track that differs from the current one
    function automatic disk_pkg::track_t new_track(input disk_pkg::track_t old);
        disk_pkg::track_t t;
        t = disk_pkg::track_t'($random(seed));
        if (t == old)
            t = t + disk_pkg::track_t'(1);
        return t;
    endfunction

    ////////////////////////////////////////
    // Stimulus helpers, entered and left on a falling edge
    ////////////////////////////////////////

    task automatic apply_colour(input video_pkg::color_index_t idx, input logic odd,
                                input video_pkg::scan_mode_t mode);
        logic [14:0] exp;
        color_index_i   = idx;
        odd_line_i      = odd;
        scanline_mode_i = mode;
        @(negedge clk_sys);
        exp = ref_rgb(idx, odd, mode, 1'b0);
        check_channel("vga_r_o", vga_r_o, exp[14:10]);
        check_channel("vga_g_o", vga_g_o, exp[9:5]);
        check_channel("vga_b_o", vga_b_o, exp[4:0]);
    endtask

    // SD host side of one whole track load
    task automatic serve_load(input disk_pkg::track_t trk);
        int wait_cnt;
        int acks;
        int delay;
        int hold;
        wait_cnt = 0;
        acks     = 0;
        while (!sd_rd_o) begin
            @(negedge clk_sys);
            wait_cnt++;
            if (wait_cnt > REQ_TIMEOUT)
                fail_run("Timeout: the loader never raised sd_rd_o");
        end
        check_bit("cpu_wait_o at load start", cpu_wait_o, 1'b1);
        while (acks < SECTORS_PER_TRACK) begin
            delay = 1 + ({$random(seed)} % 4);
            repeat (delay) @(negedge clk_sys);
            check_lba("sd_lba_o at ack", sd_lba_o, ref_first_lba(trk) + disk_pkg::lba_t'(acks));
            sd_ack_i = 1'b1;
            acks++;
            hold = 1 + ({$random(seed)} % 3);
            repeat (hold) @(negedge clk_sys);
            sd_ack_i = 1'b0;
            // Loader sees the falling edge
            @(negedge clk_sys);
            check_bit("cpu_wait_o after ack", cpu_wait_o, 1'b0);
            check_bit("sd_rd_o after ack", sd_rd_o, acks < SECTORS_PER_TRACK);
        end
        repeat (5) begin
            @(negedge clk_sys);
            check_bit("sd_rd_o after load", sd_rd_o, 1'b0);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        disk_pkg::track_t trk;
        reset           = 1'b1;
        reset_req_i     = 1'b0;
        track_i         = '0;
        img_mounted_i   = 1'b0;
        img_size_i      = '0;
        sd_ack_i        = 1'b0;
        drive_active_i  = 1'b0;
        color_index_i   = '0;
        odd_line_i      = 1'b0;
        scanline_mode_i = video_pkg::SCAN_OFF;
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        reset = 1'b0;

        // Reset stretch
        reset_req_i = 1'b1;
        @(negedge clk_sys);
        reset_req_i = 1'b0;
        check_bit("core_reset_o after request", core_reset_o, 1'b1);
        for (int k = 1; k <= RESET_EDGES; k++) begin
            @(negedge clk_sys);
            check_bit("core_reset_o during hold", core_reset_o, k < RESET_EDGES);
        end

        // Track load with an image present
        trk        = new_track(track_i);
        img_size_i = IMG_BYTES;
        track_i    = trk;
        serve_load(trk);

        // No image, then a mount of the same track
        img_size_i = '0;
        trk        = new_track(track_i);
        track_i    = trk;
        repeat (20) begin
            @(negedge clk_sys);
            check_bit("sd_rd_o without image", sd_rd_o, 1'b0);
        end
        img_size_i    = IMG_BYTES;
        img_mounted_i = 1'b1;
        @(negedge clk_sys);
        img_mounted_i = 1'b0;
        serve_load(trk);

        // Every index in every mode, then random vectors
        for (int m = 0; m < 4; m++) begin
            for (int i = 0; i < 16; i++) begin
                apply_colour(video_pkg::color_index_t'(i), logic'($random(seed)),
                             video_pkg::scan_mode_t'(m));
            end
        end
        repeat (32) begin
            apply_colour(video_pkg::color_index_t'($random(seed)), logic'($random(seed)),
                         video_pkg::scan_mode_t'($random(seed)));
        end

        // Disk activity overlay, dim50 odd line keeps green below all ones
        color_index_i   = video_pkg::color_index_t'($random(seed));
        odd_line_i      = 1'b1;
        scanline_mode_i = video_pkg::SCAN_DIM50;
        drive_active_i  = 1'b1;
        for (int k = 0; k <= OVERLAY_EDGES + 1; k++) begin
            @(negedge clk_sys);
            drive_active_i = 1'b0;
            check_bit("overlay", UUT.overlay, k < OVERLAY_EDGES);
            exp_rgb = ref_rgb(color_index_i, 1'b1, video_pkg::SCAN_DIM50,
                              k >= 1 && k <= OVERLAY_EDGES);
            check_channel("vga_r_o with overlay", vga_r_o, exp_rgb[14:10]);
            check_channel("vga_g_o with overlay", vga_g_o, exp_rgb[9:5]);
            check_channel("vga_b_o with overlay", vga_b_o, exp_rgb[4:0]);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
hdl/disk_pkg.sv
hdl/video_pkg.sv
hdl/reset_sequencer.sv
hdl/track_loader.sv
hdl/activity_timer.sv
hdl/palette_shader.sv
hdl/tk2000_support.sv
tests/tk2000_support_props.sv
tests/tb_tk2000_support.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; the exit status is the simulation result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module tb_tk2000_support \
    -f compile.f \
    -o tb_tk2000_support
./obj_dir/tb_tk2000_support
